/* sources.f */
verilog/nand_pkg.sv
verilog/nand_write_cycle.sv
verilog/nand_read_cycle.sv
verilog/nand_sequencer.sv
verilog/host_regs.sv
verilog/nand_master.sv
sim/tb_clock.sv
sim/nand_chip_model.sv
sim/tb_nand_master.sv

/* run.sh */
#!/bin/sh
# build the nand master testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_nand_master \
	-o sim_nand_master || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_nand_master 2>&1)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* sim/tb_nand_master.sv */
//------------------------------
// nand master testbench
// table of host opcodes run against a behavioral chip
//------------------------------
`timescale 1ns/1ps

module tb_nand_master;

	// id bytes, byte 0 in the low bits
	localparam logic [39:0] CHIP_ID = 40'h04_95_80_f1_2c;
	localparam logic [7:0] CHIP_STATUS = 8'he0;
	localparam int ROWS = 24;
	localparam int OP_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 10;

	typedef enum logic [1:0] {CHK_NONE, CHK_BYTE, CHK_STATUS} chk_kind_t;

	// one opcode with its expected result
	typedef struct packed {
		nand_pkg::host_cmd_t cmd;
		logic [7:0]          din;
		logic [7:0]          exp;
		chk_kind_t           chk;
	} op_row_t;

	logic clk;
	logic nreset;
	logic activate;
	nand_pkg::host_cmd_t cmd_in;
	logic [7:0] data_in;
	logic busy;
	logic [7:0] data_out;
	nand_pkg::nand_pins_t nand_pins;
	logic nand_nce;
	logic nand_nwp;
	logic nand_rnb;
	logic [7:0] nand_dq_in;
	logic [7:0] last_cmd;
	logic [7:0] last_addr;
	logic [7:0] last_data;

	op_row_t rows [ROWS];
	integer seed;
	logic [7:0] rnd_cmd;
	logic [7:0] rnd_addr;
	logic [7:0] rnd_data;
	logic exp_nce;
	int cycles;
	int wait_n;
	nand_pkg::nand_pins_t idle_pins;

	tb_clock i_clock (.clk(clk), .nreset(nreset));

	nand_master i_nand_master (
		.clk(clk), .nreset(nreset), .activate(activate), .cmd_in(cmd_in),
		.data_in(data_in), .busy(busy), .data_out(data_out), .nand_pins(nand_pins),
		.nand_nce(nand_nce), .nand_nwp(nand_nwp), .nand_rnb(nand_rnb),
		.nand_dq_in(nand_dq_in)
	);

	nand_chip_model #(.ID(CHIP_ID), .STATUS(CHIP_STATUS)) i_chip_model (
		.clk(clk), .nreset(nreset), .pins(nand_pins), .nce(nand_nce), .rnb(nand_rnb),
		.dq(nand_dq_in), .last_cmd(last_cmd), .last_addr(last_addr), .last_data(last_data)
	);

	//------------------------------
	// helpers
	//------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %02h, expected %02h", $time, what, got, exp));
		end
	endtask

	task automatic check_status(input nand_pkg::ctrl_status_t got,
			input nand_pkg::ctrl_status_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t status: got %08b, expected %08b", $time, got, exp));
		end
	endtask

	// dq only matters while the controller drives it
	task automatic check_pins(input nand_pkg::nand_pins_t got, input nand_pkg::nand_pins_t exp);
		if ({got.cle, got.ale, got.nwe, got.nre, got.dq_oe} !==
				{exp.cle, exp.ale, exp.nwe, exp.nre, exp.dq_oe} ||
				(exp.dq_oe && (got.dq !== exp.dq))) begin
			abort_run($sformatf("FAIL %0t pins: got %b, expected %b", $time, got, exp));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("FAIL %0t %s: got %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	// bit 2 chip enabled, bit 3 write protected, bit 4 index out of range
	function automatic logic [7:0] status_byte(input logic en, input logic oor);
		return {3'b000, oor, 1'b1, en, 2'b00};
	endfunction

	function automatic logic [7:0] id_byte(input int i);
		return CHIP_ID[i * 8 +: 8];
	endfunction

	function automatic logic is_reg_only(input nand_pkg::host_cmd_t cmd);
		return (cmd == nand_pkg::CMD_GET_STATUS) || (cmd == nand_pkg::CMD_CHIP_ENABLE) ||
			(cmd == nand_pkg::CMD_CHIP_DISABLE) || (cmd == nand_pkg::CMD_RESET_INDEX) ||
			(cmd == nand_pkg::CMD_GET_ID_BYTE);
	endfunction

	function automatic op_row_t make_row(input nand_pkg::host_cmd_t cmd, input logic [7:0] din,
			input logic [7:0] exp, input chk_kind_t chk);
		op_row_t r;
		r.cmd = cmd;
		r.din = din;
		r.exp = exp;
		r.chk = chk;
		return r;
	endfunction

	//------------------------------
	// stimulus table
	//------------------------------
	task automatic fill_rows();
		// enable and disable around status reads
		rows[0] = make_row(nand_pkg::CMD_GET_STATUS, 8'h00, status_byte(1'b0, 1'b0), CHK_STATUS);
		rows[1] = make_row(nand_pkg::CMD_CHIP_ENABLE, 8'h00, 8'h00, CHK_NONE);
		rows[2] = make_row(nand_pkg::CMD_GET_STATUS, 8'h00, status_byte(1'b1, 1'b0), CHK_STATUS);
		rows[3] = make_row(nand_pkg::CMD_CHIP_DISABLE, 8'h00, 8'h00, CHK_NONE);
		rows[4] = make_row(nand_pkg::CMD_GET_STATUS, 8'h00, status_byte(1'b0, 1'b0), CHK_STATUS);
		rows[5] = make_row(nand_pkg::CMD_CHIP_ENABLE, 8'h00, 8'h00, CHK_NONE);
		// chip reset and id read, then walk the buffer
		rows[6] = make_row(nand_pkg::CMD_NAND_RESET, 8'h00, 8'h00, CHK_NONE);
		rows[7] = make_row(nand_pkg::CMD_READ_ID, 8'h00, 8'h00, CHK_NONE);
		rows[8] = make_row(nand_pkg::CMD_RESET_INDEX, 8'h00, 8'h00, CHK_NONE);
		for (int k = 0; k < 5; k++) begin
			rows[9 + k] = make_row(nand_pkg::CMD_GET_ID_BYTE, 8'h00, id_byte(k), CHK_BYTE);
		end
		// one past the end, then back in range
		rows[14] = make_row(nand_pkg::CMD_GET_ID_BYTE, 8'h00, 8'h00, CHK_BYTE);
		rows[15] = make_row(nand_pkg::CMD_GET_STATUS, 8'h00, status_byte(1'b1, 1'b1), CHK_STATUS);
		rows[16] = make_row(nand_pkg::CMD_GET_ID_BYTE, 8'h00, id_byte(0), CHK_BYTE);
		rows[17] = make_row(nand_pkg::CMD_GET_STATUS, 8'h00, status_byte(1'b1, 1'b0), CHK_STATUS);
		rows[18] = make_row(nand_pkg::CMD_READ_STATUS, 8'h00, CHIP_STATUS, CHK_BYTE);
		// raw bytes, the chip reads back the last data byte written
		rows[19] = make_row(nand_pkg::CMD_BYPASS_COMMAND, rnd_cmd, 8'h00, CHK_NONE);
		rows[20] = make_row(nand_pkg::CMD_BYPASS_ADDRESS, rnd_addr, 8'h00, CHK_NONE);
		rows[21] = make_row(nand_pkg::CMD_BYPASS_DATA_WR, rnd_data, 8'h00, CHK_NONE);
		rows[22] = make_row(nand_pkg::CMD_BYPASS_DATA_RD, 8'h00, rnd_data, CHK_BYTE);
		rows[23] = make_row(nand_pkg::CMD_GET_STATUS, 8'h00, status_byte(1'b1, 1'b0), CHK_STATUS);
	endtask

	// one activate pulse, then count cycles with busy high
	task automatic run_op(input op_row_t r, output int n);
		activate = 1'b1;
		cmd_in = r.cmd;
		data_in = r.din;
		@(negedge clk);
		activate = 1'b0;
		n = 0;
		while (busy && (n < OP_TIMEOUT)) begin
			n++;
			@(negedge clk);
		end
		if (busy) begin
			abort_run($sformatf("timeout: busy still high after %0d cycles, opcode %0d", n, r.cmd));
		end
	endtask

	//------------------------------
	// main sequence
	//------------------------------
	initial begin
		activate = 1'b0;
		cmd_in = nand_pkg::CMD_GET_STATUS;
		data_in = 8'h00;
		exp_nce = 1'b1;
		seed = 32'h2a61_3090;
		idle_pins = '0;
		idle_pins.nwe = 1'b1;
		idle_pins.nre = 1'b1;
		rnd_cmd = 8'($random(seed));
		rnd_addr = 8'($random(seed));
		rnd_data = 8'($random(seed));
		fill_rows();

		wait_n = 0;
		@(negedge clk);
		while (!nreset && (wait_n < RESET_TIMEOUT)) begin
			wait_n++;
			@(negedge clk);
		end
		if (!nreset) begin
			abort_run("timeout: reset was never released");
		end

		// levels straight after reset
		check_flag("busy", busy, 1'b0);
		check_flag("nand_nce", nand_nce, 1'b1);
		check_flag("nand_nwp", nand_nwp, 1'b0);
		check_pins(nand_pins, idle_pins);

		for (int i = 0; i < ROWS; i++) begin
			run_op(rows[i], cycles);
			if (is_reg_only(rows[i].cmd)) begin
				check_count("busy cycles", cycles, 2);
			end
			case (rows[i].chk)
				CHK_BYTE: check_byte("data_out", data_out, rows[i].exp);
				CHK_STATUS: check_status(nand_pkg::ctrl_status_t'(data_out),
					nand_pkg::ctrl_status_t'(rows[i].exp));
				default: ;
			endcase
			// ce# follows the enable opcodes only
			if (rows[i].cmd == nand_pkg::CMD_CHIP_ENABLE) begin
				exp_nce = 1'b0;
			end else if (rows[i].cmd == nand_pkg::CMD_CHIP_DISABLE) begin
				exp_nce = 1'b1;
			end
			check_flag("nand_nce", nand_nce, exp_nce);
			case (rows[i].cmd)
				nand_pkg::CMD_BYPASS_COMMAND: check_byte("chip command", last_cmd, rows[i].din);
				nand_pkg::CMD_BYPASS_ADDRESS: check_byte("chip address", last_addr, rows[i].din);
				nand_pkg::CMD_BYPASS_DATA_WR: check_byte("chip data", last_data, rows[i].din);
				default: ;
			endcase
			check_pins(nand_pins, idle_pins);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sim/nand_chip_model.sv */
//------------------------------
// behavioral nand chip
// answers reset, read id, read status and raw bytes
//------------------------------
`timescale 1ns/1ps

module nand_chip_model #(
	parameter logic [39:0] ID = '0,
	parameter logic [7:0] STATUS = 8'he0
) (
	input  logic                 clk,
	input  logic                 nreset,
	input  nand_pkg::nand_pins_t pins,
	input  logic                 nce,
	output logic                 rnb,
	output logic [7:0]           dq,
	output logic [7:0]           last_cmd,
	output logic [7:0]           last_addr,
	output logic [7:0]           last_data
);

	// r/b# low time after reset and after the read id address
	localparam int RB_CLOCKS = 10;

	typedef enum logic [2:0] {M_IDLE, M_ID_ADDR, M_ID, M_STATUS, M_RAW} mode_t;

	mode_t mode;
	logic [2:0] ptr;
	logic prev_nwe;
	logic prev_nre;
	int busy_cnt;

	//------------------------------
	// strobe decode
	//------------------------------
	// pins are sampled on the clock, a rising we# or re# is seen one edge late
	always @(posedge clk) begin
		if (!nreset) begin
			mode <= M_IDLE;
			ptr <= '0;
			prev_nwe <= 1'b1;
			prev_nre <= 1'b1;
			busy_cnt <= 0;
			last_cmd <= 8'h00;
			last_addr <= 8'h00;
			last_data <= 8'h00;
		end else begin
			prev_nwe <= pins.nwe;
			prev_nre <= pins.nre;
			if (busy_cnt != 0) begin
				busy_cnt <= busy_cnt - 1;
			end
			// byte latched on the rising edge of we#
			if (!nce && !prev_nwe && pins.nwe) begin
				if (pins.cle) begin
					last_cmd <= pins.dq;
					case (pins.dq)
						8'hff: begin
							mode <= M_IDLE;
							busy_cnt <= RB_CLOCKS;
						end
						8'h90: mode <= M_ID_ADDR;
						8'h70: mode <= M_STATUS;
						default: mode <= M_IDLE;
					endcase
				end else if (pins.ale) begin
					last_addr <= pins.dq;
					if (mode == M_ID_ADDR) begin
						mode <= M_ID;
						ptr <= '0;
						busy_cnt <= RB_CLOCKS;
					end
				end else begin
					// raw data write loops back on later reads
					last_data <= pins.dq;
					mode <= M_RAW;
				end
			end
			// next id byte after each re# pulse
			if (!nce && !prev_nre && pins.nre && (mode == M_ID)) begin
				ptr <= (ptr == 3'd4) ? 3'd0 : ptr + 3'd1;
			end
		end
	end

	assign rnb = (busy_cnt == 0);

	always_comb begin
		case (mode)
			M_ID: dq = ID[int'(ptr) * 8 +: 8];
			M_STATUS: dq = STATUS;
			M_RAW: dq = last_data;
			default: dq = 8'h00;
		endcase
	end

endmodule

/* sim/tb_clock.sv */
//------------------------------
// testbench clock and reset
// 20 ns clock, reset low for two cycles
//------------------------------
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic nreset
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		nreset = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;
	end

endmodule

/* verilog/nand_master.sv */
//----------------------------
// nand master top level
// host activate/busy port to an 8-bit onfi bus
//----------------------------
`timescale 1ns/1ps

module nand_master (
	input  logic                 clk,
	input  logic                 nreset,
	input  logic                 activate,
	input  nand_pkg::host_cmd_t  cmd_in,
	input  logic [7:0]           data_in,
	output logic                 busy,
	output logic [7:0]           data_out,
	output nand_pkg::nand_pins_t nand_pins,
	output logic                 nand_nce,
	output logic                 nand_nwp,
	input  logic                 nand_rnb,
	input  logic [7:0]           nand_dq_in
);

	logic wr_start;
	nand_pkg::cycle_kind_t wr_kind;
	logic [7:0] wr_byte;
	logic wr_busy;
	nand_pkg::nand_pins_t wr_pins;
	logic rd_start;
	logic rd_busy;
	logic [7:0] rd_byte;
	logic rd_nre;
	nand_pkg::reg_op_t reg_op;
	logic [7:0] reg_byte;
	nand_pkg::ctrl_status_t status;

	nand_sequencer i_sequencer (
		.clk(clk), .nreset(nreset), .activate(activate), .cmd_in(cmd_in),
		.data_in(data_in), .nand_rnb(nand_rnb), .wr_busy(wr_busy), .rd_busy(rd_busy),
		.rd_byte(rd_byte), .wr_start(wr_start), .wr_kind(wr_kind), .wr_byte(wr_byte),
		.rd_start(rd_start), .reg_op(reg_op), .reg_byte(reg_byte), .busy(busy),
		.nand_nce(nand_nce)
	);

	nand_write_cycle i_write_cycle (
		.clk(clk), .nreset(nreset), .start(wr_start), .kind(wr_kind),
		.data(wr_byte), .busy(wr_busy), .pins(wr_pins)
	);

	nand_read_cycle i_read_cycle (
		.clk(clk), .nreset(nreset), .start(rd_start), .dq_in(nand_dq_in),
		.busy(rd_busy), .rd_byte(rd_byte), .nre(rd_nre)
	);

	host_regs i_host_regs (
		.clk(clk), .nreset(nreset), .reg_op(reg_op), .reg_byte(reg_byte),
		.data_out(data_out), .status(status)
	);

	// only one generator runs at a time so the strobes merge by and
	always_comb begin
		nand_pins = wr_pins;
		nand_pins.nre = wr_pins.nre & rd_nre;
	end

	// chip stays write protected
	assign nand_nwp = 1'b0;

	// ce# and the status flag move in the same clock
	a_ce_matches_status: assert property (@(posedge clk) disable iff (!nreset)
		!busy |-> (nand_nce == !status.chip_en));

	a_one_generator: assert property (@(posedge clk) disable iff (!nreset)
		!(wr_busy && rd_busy));

endmodule

/* verilog/host_regs.sv */
//----------------------------
// host register file
// status flags, id buffer, index and data_out
//----------------------------
`timescale 1ns/1ps

module host_regs (
	input  logic                   clk,
	input  logic                   nreset,
	input  nand_pkg::reg_op_t      reg_op,
	input  logic [7:0]             reg_byte,
	output logic [7:0]             data_out,
	output nand_pkg::ctrl_status_t status
);

	logic [7:0] id_buf [nand_pkg::ID_BYTES];
	logic [nand_pkg::IDX_W-1:0] index;
	logic [nand_pkg::IDX_W-1:0] fill_ptr;
	logic chip_en;
	logic index_oor;
	logic in_range;

	assign in_range = (index <= nand_pkg::ID_LAST);

	//----------------------------
	// flags and pointers
	//----------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			index <= '0;
			fill_ptr <= '0;
			chip_en <= 1'b0;
			index_oor <= 1'b0;
		end else begin
			case (reg_op)
				nand_pkg::REG_CHIP_ENABLE: chip_en <= 1'b1;
				nand_pkg::REG_CHIP_DISABLE: chip_en <= 1'b0;
				nand_pkg::REG_RESET_INDEX: index <= '0;
				nand_pkg::REG_GET_ID_BYTE: begin
					// past the end wraps to 0 and flags it
					index <= in_range ? index + 1'b1 : '0;
					index_oor <= !in_range;
				end
				// fill pointer wraps after a full id read
				nand_pkg::REG_LOAD_ID:
					fill_ptr <= (fill_ptr == nand_pkg::ID_LAST) ? '0 : fill_ptr + 1'b1;
				default: ;
			endcase
		end
	end

	// byte moves into the buffer or out to the host
	always_ff @(posedge clk) begin
		case (reg_op)
			nand_pkg::REG_GET_STATUS: data_out <= status;
			nand_pkg::REG_GET_ID_BYTE: data_out <= in_range ? id_buf[index] : 8'h00;
			nand_pkg::REG_LOAD_ID: id_buf[fill_ptr] <= reg_byte;
			nand_pkg::REG_LOAD_DATA: data_out <= reg_byte;
			default: ;
		endcase
	end

	// wp# is tied low, so always write protected
	always_comb begin
		status = '0;
		status.chip_en = chip_en;
		status.write_prot = 1'b1;
		status.index_oor = index_oor;
	end

	a_index_bound: assert property (@(posedge clk) disable iff (!nreset)
		int'(index) <= nand_pkg::ID_BYTES);

endmodule

/* verilog/nand_sequencer.sv */
//----------------------------
// nand sequencer
// decodes host opcodes into nand cycle sequences,
// waits on delays and r/b#, owns ce#
//----------------------------
`timescale 1ns/1ps

module nand_sequencer (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  activate,
	input  nand_pkg::host_cmd_t   cmd_in,
	input  logic [7:0]            data_in,
	input  logic                  nand_rnb,
	input  logic                  wr_busy,
	input  logic                  rd_busy,
	input  logic [7:0]            rd_byte,
	output logic                  wr_start,
	output nand_pkg::cycle_kind_t wr_kind,
	output logic [7:0]            wr_byte,
	output logic                  rd_start,
	output nand_pkg::reg_op_t     reg_op,
	output logic [7:0]            reg_byte,
	output logic                  busy,
	output logic                  nand_nce
);

	nand_pkg::seq_state_t state;
	nand_pkg::host_cmd_t cmd_q;
	logic [7:0] data_q;
	logic [2:0] step;
	logic [2:0] next_step;
	logic [nand_pkg::DELAY_W-1:0] count;
	logic [nand_pkg::IDX_W-1:0] id_cnt;
	nand_pkg::reg_op_t imm_op;

	// action decoded for the current step
	logic act_wr;
	logic act_rd;
	logic act_delay;
	logic act_done;
	nand_pkg::cycle_kind_t act_kind;
	logic [7:0] act_byte;
	nand_pkg::reg_op_t act_op;
	logic [nand_pkg::DELAY_W-1:0] act_cnt;

	// register-only opcodes map straight onto a register op
	always_comb begin
		case (cmd_q)
			nand_pkg::CMD_GET_STATUS:   imm_op = nand_pkg::REG_GET_STATUS;
			nand_pkg::CMD_CHIP_ENABLE:  imm_op = nand_pkg::REG_CHIP_ENABLE;
			nand_pkg::CMD_CHIP_DISABLE: imm_op = nand_pkg::REG_CHIP_DISABLE;
			nand_pkg::CMD_RESET_INDEX:  imm_op = nand_pkg::REG_RESET_INDEX;
			nand_pkg::CMD_GET_ID_BYTE:  imm_op = nand_pkg::REG_GET_ID_BYTE;
			default:                    imm_op = nand_pkg::REG_NONE;
		endcase
	end

	//----------------------------
	// per-opcode step table
	//----------------------------
	always_comb begin
		act_wr = 1'b0;
		act_rd = 1'b0;
		act_delay = 1'b0;
		act_done = 1'b0;
		act_kind = nand_pkg::CYC_CMD;
		act_byte = data_q;
		act_op = nand_pkg::REG_NONE;
		act_cnt = '0;
		next_step = step + 3'd1;
		case (cmd_q)
			nand_pkg::CMD_NAND_RESET: begin
				// ffh, then tWB and r/b# high
				act_wr = (step == 3'd0);
				act_byte = nand_pkg::NAND_CMD_RESET;
				act_cnt = nand_pkg::T_WB;
				act_done = (step != 3'd0);
			end
			nand_pkg::CMD_GET_STATUS, nand_pkg::CMD_CHIP_ENABLE, nand_pkg::CMD_CHIP_DISABLE,
			nand_pkg::CMD_RESET_INDEX, nand_pkg::CMD_GET_ID_BYTE: begin
				// one op step and one closing step
				if (step == 3'd0) begin
					act_op = imm_op;
				end else begin
					act_done = 1'b1;
				end
			end
			nand_pkg::CMD_READ_ID: begin
				case (step)
					3'd0: begin
						act_wr = 1'b1;
						act_byte = nand_pkg::NAND_CMD_READ_ID;
					end
					3'd1: begin
						act_wr = 1'b1;
						act_kind = nand_pkg::CYC_ADDR;
						act_byte = 8'h00;
						act_cnt = nand_pkg::T_WB;
					end
					3'd2: begin
						act_delay = 1'b1;
						act_cnt = nand_pkg::T_RR;
					end
					3'd3: act_rd = 1'b1;
					3'd4: begin
						// store byte, loop back for the next read
						act_op = nand_pkg::REG_LOAD_ID;
						if (id_cnt != nand_pkg::ID_LAST) begin
							next_step = 3'd3;
						end
					end
					default: act_done = 1'b1;
				endcase
			end
			nand_pkg::CMD_READ_STATUS: begin
				case (step)
					3'd0: begin
						act_wr = 1'b1;
						act_byte = nand_pkg::NAND_CMD_READ_STATUS;
					end
					3'd1: begin
						act_delay = 1'b1;
						act_cnt = nand_pkg::T_WHR;
					end
					3'd2: act_rd = 1'b1;
					3'd3: act_op = nand_pkg::REG_LOAD_DATA;
					default: act_done = 1'b1;
				endcase
			end
			nand_pkg::CMD_BYPASS_COMMAND, nand_pkg::CMD_BYPASS_ADDRESS,
			nand_pkg::CMD_BYPASS_DATA_WR: begin
				// raw byte from data_in
				act_wr = (step == 3'd0);
				act_done = (step != 3'd0);
				if (cmd_q == nand_pkg::CMD_BYPASS_ADDRESS) begin
					act_kind = nand_pkg::CYC_ADDR;
				end else if (cmd_q == nand_pkg::CMD_BYPASS_DATA_WR) begin
					act_kind = nand_pkg::CYC_DATA;
				end
				if (cmd_q != nand_pkg::CMD_BYPASS_DATA_WR) begin
					act_cnt = nand_pkg::T_WB;
				end
			end
			nand_pkg::CMD_BYPASS_DATA_RD: begin
				act_rd = (step == 3'd0);
				if (step == 3'd1) begin
					act_op = nand_pkg::REG_LOAD_DATA;
				end
				act_done = (step > 3'd1);
			end
			// unknown opcode ends at once
			default: act_done = 1'b1;
		endcase
	end

	//----------------------------
	// state machine
	//----------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= nand_pkg::SEQ_IDLE;
			step <= '0;
			count <= '0;
			id_cnt <= '0;
			nand_nce <= 1'b1;
		end else begin
			case (state)
				nand_pkg::SEQ_IDLE: begin
					if (activate) begin
						state <= nand_pkg::SEQ_RUN;
						step <= '0;
						id_cnt <= '0;
					end
				end
				nand_pkg::SEQ_RUN: begin
					// step now holds the point to come back to
					step <= next_step;
					count <= act_cnt;
					if (act_done) begin
						state <= nand_pkg::SEQ_IDLE;
					end else if (act_wr || act_rd) begin
						state <= nand_pkg::SEQ_WAIT;
					end else if (act_delay) begin
						state <= nand_pkg::SEQ_DELAY;
					end
					if (act_op == nand_pkg::REG_LOAD_ID) begin
						id_cnt <= id_cnt + 1'b1;
					end
					if (act_op == nand_pkg::REG_CHIP_ENABLE) begin
						nand_nce <= 1'b0;
					end else if (act_op == nand_pkg::REG_CHIP_DISABLE) begin
						nand_nce <= 1'b1;
					end
				end
				nand_pkg::SEQ_WAIT: begin
					// countdown starts once both strobes are done
					// then hold while r/b# is low
					if (!wr_busy && !rd_busy) begin
						if (count != '0) begin
							count <= count - 1'b1;
						end else if (nand_rnb) begin
							state <= nand_pkg::SEQ_RUN;
						end
					end
				end
				nand_pkg::SEQ_DELAY: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else begin
						state <= nand_pkg::SEQ_RUN;
					end
				end
				default: state <= nand_pkg::SEQ_IDLE;
			endcase
		end
	end

	// opcode and raw byte captured on accept
	always_ff @(posedge clk) begin
		if ((state == nand_pkg::SEQ_IDLE) && activate) begin
			cmd_q <= cmd_in;
			data_q <= data_in;
		end
	end

	assign busy = (state != nand_pkg::SEQ_IDLE);
	assign wr_start = (state == nand_pkg::SEQ_RUN) && act_wr;
	assign wr_kind = act_kind;
	assign wr_byte = act_byte;
	assign rd_start = (state == nand_pkg::SEQ_RUN) && act_rd;
	assign reg_op = (state == nand_pkg::SEQ_RUN) ? act_op : nand_pkg::REG_NONE;
	// only the two load ops take a byte
	assign reg_byte = rd_byte;

	a_state_legal: assert property (@(posedge clk) disable iff (!nreset) $onehot(state));

endmodule

/* verilog/nand_read_cycle.sv */
//----------------------------
// nand read cycle
// one re# strobe, samples dq
//----------------------------
`timescale 1ns/1ps

module nand_read_cycle (
	input  logic       clk,
	input  logic       nreset,
	input  logic       start,
	input  logic [7:0] dq_in,
	output logic       busy,
	output logic [7:0] rd_byte,
	output logic       nre
);

	logic [nand_pkg::PHASE_W-1:0] phase;

	// same shape as the write strobe
	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			phase <= '0;
		end else if (start) begin
			busy <= 1'b1;
			phase <= '0;
		end else if (busy) begin
			if (phase == nand_pkg::PH_LAST) begin
				busy <= 1'b0;
			end
			phase <= phase + 1'b1;
		end
	end

	// capture on the last clock with re# low
	// byte then holds until the next read
	always_ff @(posedge clk) begin
		if (busy && (phase == nand_pkg::PH_LOW_END)) begin
			rd_byte <= dq_in;
		end
	end

	// re# low for the low phase, high for recovery
	assign nre = !(busy && (phase != '0) && (phase <= nand_pkg::PH_LOW_END));

endmodule

/* verilog/nand_write_cycle.sv */
//----------------------------
// nand write cycle
// one cle, ale or data strobe on we#
//----------------------------
`timescale 1ns/1ps

module nand_write_cycle (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  start,
	input  nand_pkg::cycle_kind_t kind,
	input  logic [7:0]            data,
	output logic                  busy,
	output nand_pkg::nand_pins_t  pins
);

	nand_pkg::cycle_kind_t kind_q;
	logic [7:0] data_q;
	logic [nand_pkg::PHASE_W-1:0] phase;
	logic strobe;

	//----------------------------
	// phase counter
	//----------------------------
	// phase 0 sets up cle/ale and dq, then we# low, then we# high
	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			phase <= '0;
		end else if (start) begin
			busy <= 1'b1;
			phase <= '0;
		end else if (busy) begin
			if (phase == nand_pkg::PH_LAST) begin
				busy <= 1'b0;
			end
			phase <= phase + 1'b1;
		end
	end

	// byte and strobe type held for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			kind_q <= kind;
			data_q <= data;
		end
	end

	assign strobe = busy && (phase != '0) && (phase <= nand_pkg::PH_LOW_END);

	always_comb begin
		pins.cle = busy && (kind_q == nand_pkg::CYC_CMD);
		pins.ale = busy && (kind_q == nand_pkg::CYC_ADDR);
		// chip latches dq on the rising edge of we#
		pins.nwe = !strobe;
		pins.nre = 1'b1;
		pins.dq = data_q;
		pins.dq_oe = busy;
	end

	// sequencer only starts an idle generator
	a_no_restart: assert property (@(posedge clk) disable iff (!nreset) start |-> !busy);

endmodule

/* verilog/nand_pkg.sv */
//----------------------------
// nand controller package
// host opcodes, fsm states, nand command bytes,
// strobe timing and the pin and status structs
//----------------------------
package nand_pkg;

	// host opcodes, one per activate pulse
	typedef enum logic [5:0] {
		CMD_NAND_RESET     = 6'd1,
		CMD_GET_STATUS     = 6'd2,
		CMD_CHIP_ENABLE    = 6'd3,
		CMD_CHIP_DISABLE   = 6'd4,
		CMD_RESET_INDEX    = 6'd5,
		CMD_GET_ID_BYTE    = 6'd6,
		CMD_READ_ID        = 6'd7,
		CMD_READ_STATUS    = 6'd8,
		CMD_BYPASS_COMMAND = 6'd9,
		CMD_BYPASS_ADDRESS = 6'd10,
		CMD_BYPASS_DATA_WR = 6'd11,
		CMD_BYPASS_DATA_RD = 6'd12
	} host_cmd_t;

	// sequencer states, one-hot
	typedef enum logic [3:0] {
		SEQ_IDLE  = 4'b0001,
		SEQ_RUN   = 4'b0010,
		SEQ_WAIT  = 4'b0100,
		SEQ_DELAY = 4'b1000
	} seq_state_t;

	// which latch strobe a write cycle produces
	typedef enum logic [1:0] {
		CYC_CMD,
		CYC_ADDR,
		CYC_DATA
	} cycle_kind_t;

	// register file operations issued by the sequencer
	typedef enum logic [2:0] {
		REG_NONE,
		REG_GET_STATUS,
		REG_CHIP_ENABLE,
		REG_CHIP_DISABLE,
		REG_RESET_INDEX,
		REG_GET_ID_BYTE,
		REG_LOAD_ID,
		REG_LOAD_DATA
	} reg_op_t;

	// nand bus outputs, dq split into value and enable
	typedef struct packed {
		logic       cle;
		logic       ale;
		logic       nwe;
		logic       nre;
		logic [7:0] dq;
		logic       dq_oe;
	} nand_pins_t;

	// controller status byte
	typedef struct packed {
		logic [2:0] reserved_hi;
		logic       index_oor;
		logic       write_prot;
		logic       chip_en;
		logic [1:0] reserved_lo;
	} ctrl_status_t;

	// nand command bytes
	localparam logic [7:0] NAND_CMD_RESET       = 8'hff;
	localparam logic [7:0] NAND_CMD_READ_ID     = 8'h90;
	localparam logic [7:0] NAND_CMD_READ_STATUS = 8'h70;

	// id buffer
	localparam int ID_BYTES = 5;
	localparam int IDX_W = 3;
	localparam logic [IDX_W-1:0] ID_LAST = IDX_W'(ID_BYTES - 1);

	// wait times in clocks
	localparam int DELAY_W = 4;
	localparam logic [DELAY_W-1:0] T_WB = 4'd4;
	localparam logic [DELAY_W-1:0] T_WHR = 4'd6;
	localparam logic [DELAY_W-1:0] T_RR = 4'd2;

	// strobe shape, one setup clock then low and high phases
	localparam int STROBE_LOW = 2;
	localparam int STROBE_HIGH = 2;
	localparam int PHASE_W = 3;
	localparam logic [PHASE_W-1:0] PH_LOW_END = PHASE_W'(STROBE_LOW);
	localparam logic [PHASE_W-1:0] PH_LAST = PHASE_W'(STROBE_LOW + STROBE_HIGH);

endpackage
